//--- common/cache_pkg.sv
// cache geometry, address field types, processor request and fill beat structs
package cache_pkg;

  // geometry, per cache
  localparam int num_sets        = 64;
  localparam int words_per_block = 8;
  localparam int num_ways        = 2;

  // field widths of a byte address
  localparam int addr_w = 16;
  localparam int word_w = 16;
  localparam int tag_w  = 6;
  localparam int idx_w  = 6;
  localparam int off_w  = 3;  // word within block, byte bit below it is dropped

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [word_w-1:0] word_t;
  typedef logic [tag_w-1:0]  tag_t;
  typedef logic [idx_w-1:0]  set_idx_t;
  typedef logic [off_w-1:0]  word_off_t;

  // processor request, i-cache ignores write and wdata
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    word_t wdata;
  } cpu_req_t;

  // one word of a block fill from the controller
  typedef struct packed {
    logic      valid;
    word_off_t off;
    word_t     data;
    logic      last;   // final word of the block
  } fill_beat_t;

endpackage

//--- common/axi_lite_pkg.sv
// axi4-lite bus widths, response enum and channel structs
package axi_lite_pkg;

  localparam int axi_addr_w = 16;
  localparam int axi_data_w = 16;
  localparam int axi_strb_w = axi_data_w / 8;

  typedef enum logic [1:0] {
    okay   = 2'b00,
    exokay = 2'b01,
    slverr = 2'b10,
    decerr = 2'b11
  } axi_resp_e;

  typedef struct packed {
    logic                  valid;
    logic [axi_addr_w-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic                  valid;
    logic [axi_addr_w-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic                  valid;
    logic [axi_data_w-1:0] data;
    logic [axi_strb_w-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic                  valid;
    logic [axi_data_w-1:0] data;
    axi_resp_e             resp;
  } axi_r_t;

  typedef struct packed {
    logic      valid;
    axi_resp_e resp;
  } axi_b_t;

  // master driven side
  typedef struct packed {
    axi_aw_t aw;
    axi_w_t  w;
    axi_ar_t ar;
    logic    bready;
    logic    rready;
  } axi_req_t;

  // slave driven side
  typedef struct packed {
    logic   awready;
    logic   wready;
    logic   arready;
    axi_b_t b;
    axi_r_t r;
  } axi_rsp_t;

endpackage

//--- cache/meta_data_array.sv
// valid bits, tags and per-set lru bits for two ways, hit compare and victim choice
`timescale 1ns/1ns

module meta_data_array (
  input  logic                clk,
  input  logic                reset,
  input  cache_pkg::set_idx_t idx,
  input  cache_pkg::tag_t     tag,
  input  logic                access,     // request present this cycle
  input  logic                fill_done,  // last fill beat, install tag
  output logic                hit,
  output logic                hit_way,
  output logic                victim_way
);
  import cache_pkg::*;

  logic [num_ways-1:0][num_sets-1:0] valid_q;
  logic [num_sets-1:0]               lru_q;    // holds the least recently used way
  tag_t                              tag_q [num_ways][num_sets];
  logic [num_ways-1:0]               way_hit;

  // both ways compared at once
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
    end
  end

  assign hit     = |way_hit;
  assign hit_way = way_hit[1];  // only meaningful with hit

  // empty way first, otherwise lru
  always_comb begin
    if (!valid_q[0][idx]) begin
      victim_way = 1'b0;
    end else if (!valid_q[1][idx]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru_q[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      lru_q   <= '0;
    end else if (fill_done) begin
      valid_q[victim_way][idx] <= 1'b1;
      lru_q[idx]               <= ~victim_way;  // filled way is now newest
    end else if (access && hit) begin
      lru_q[idx] <= ~hit_way;
    end
  end

  // tag store, only written at the end of a fill
  always_ff @(posedge clk) begin
    if (fill_done) begin
      tag_q[victim_way][idx] <= tag;
    end
  end

endmodule

//--- cache/data_array.sv
// word storage for two ways of 64 blocks, one combinational read and one write port
`timescale 1ns/1ns

module data_array (
  input  logic                 clk,
  input  cache_pkg::set_idx_t  idx,
  input  cache_pkg::word_off_t off,     // read offset
  input  logic                 rd_way,
  input  logic                 we,
  input  logic                 wr_way,
  input  cache_pkg::word_off_t wr_off,
  input  cache_pkg::word_t     wdata,
  output cache_pkg::word_t     rdata
);
  import cache_pkg::*;

  // flat store, address is {way, set, word}
  word_t mem_q [num_ways*num_sets*words_per_block];

  logic [idx_w+off_w:0] rd_addr;
  logic [idx_w+off_w:0] wr_addr;

  assign rd_addr = {rd_way, idx, off};
  assign wr_addr = {wr_way, idx, wr_off};

  // read is same cycle as the request
  assign rdata = mem_q[rd_addr];

  always_ff @(posedge clk) begin
    if (we) begin
      mem_q[wr_addr] <= wdata;
    end
  end

endmodule

//--- cache/i_cache.sv
// instruction cache with address decode, metadata and data arrays, hit data select
`timescale 1ns/1ns

module i_cache (
  input  logic                  clk,
  input  logic                  reset,
  input  cache_pkg::cpu_req_t   req,
  input  cache_pkg::fill_beat_t beat,
  output cache_pkg::word_t      rdata,
  output logic                  miss,
  output logic                  fill_req,
  output cache_pkg::addr_t      fill_addr
);
  import cache_pkg::*;

  tag_t      tag;
  set_idx_t  idx;
  word_off_t off;
  logic      hit;
  logic      hit_way;
  logic      victim_way;
  logic      fill_done;

  // tag | set | word, byte bit dropped
  assign {tag, idx, off} = req.addr[addr_w-1:1];

  assign miss      = req.valid & ~hit;
  assign fill_req  = miss;                           // held until the block lands
  assign fill_addr = {tag, idx, {(off_w+1){1'b0}}};  // block aligned
  assign fill_done = beat.valid & beat.last;

  meta_data_array u_meta (
    .clk        (clk),
    .reset      (reset),
    .idx        (idx),
    .tag        (tag),
    .access     (req.valid),
    .fill_done  (fill_done),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  // fill beats always go to the victim way
  data_array u_data (
    .clk    (clk),
    .idx    (idx),
    .off    (off),
    .rd_way (hit_way),
    .we     (beat.valid),
    .wr_way (victim_way),
    .wr_off (beat.off),
    .wdata  (beat.data),
    .rdata  (rdata)
  );

endmodule

//--- cache/d_cache.sv
// data cache with write-hit update and write-through request to memory
`timescale 1ns/1ns

module d_cache (
  input  logic                  clk,
  input  logic                  reset,
  input  cache_pkg::cpu_req_t   req,
  input  cache_pkg::fill_beat_t beat,
  output cache_pkg::word_t      rdata,
  output logic                  stall,
  output logic                  fill_req,
  output cache_pkg::addr_t      fill_addr,
  output logic                  wt_req,
  output cache_pkg::addr_t      wt_addr,
  output cache_pkg::word_t      wt_data,
  input  logic                  wt_done
);
  import cache_pkg::*;

  tag_t      tag;
  set_idx_t  idx;
  word_off_t off;
  logic      hit;
  logic      hit_way;
  logic      victim_way;
  logic      fill_done;
  logic      rd_miss;
  logic      wr_hit;
  logic      wt_done_q;   // write acknowledged last cycle
  logic      arr_we;
  logic      arr_way;
  word_off_t arr_off;
  word_t     arr_wdata;

  assign {tag, idx, off} = req.addr[addr_w-1:1];

  assign rd_miss   = req.valid & ~req.write & ~hit;
  assign wr_hit    = req.valid & req.write & hit;
  assign fill_done = beat.valid & beat.last;

  // no write allocate, only reads fetch a block
  assign fill_req  = rd_miss;
  assign fill_addr = {tag, idx, {(off_w+1){1'b0}}};

  // every write goes out, request drops the cycle after the b response
  assign wt_req  = req.valid & req.write & ~wt_done_q;
  assign wt_addr = req.addr;
  assign wt_data = req.wdata;
  assign stall   = rd_miss | wt_req;

  always_ff @(posedge clk) begin
    if (reset) begin
      wt_done_q <= 1'b0;
    end else begin
      wt_done_q <= wt_done;
    end
  end

  // fill and write hit never overlap, processor is stalled during a fill
  assign arr_we    = beat.valid | wr_hit;
  assign arr_way   = beat.valid ? victim_way : hit_way;
  assign arr_off   = beat.valid ? beat.off : off;
  assign arr_wdata = beat.valid ? beat.data : req.wdata;

  meta_data_array u_meta (
    .clk        (clk),
    .reset      (reset),
    .idx        (idx),
    .tag        (tag),
    .access     (req.valid),  // write hits count as use too
    .fill_done  (fill_done),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  data_array u_data (
    .clk    (clk),
    .idx    (idx),
    .off    (off),
    .rd_way (hit_way),
    .we     (arr_we),
    .wr_way (arr_way),
    .wr_off (arr_off),
    .wdata  (arr_wdata),
    .rdata  (rdata)
  );

endmodule

//--- verilog/mem_fill_ctrl.sv
// miss and write-through arbiter, eight-read block fill and single write over axi4-lite
`timescale 1ns/1ns

module mem_fill_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_fill_req,
  input  cache_pkg::addr_t       i_fill_addr,
  output cache_pkg::fill_beat_t  i_beat,
  input  logic                   d_fill_req,
  input  cache_pkg::addr_t       d_fill_addr,
  output cache_pkg::fill_beat_t  d_beat,
  input  logic                   d_wt_req,
  input  cache_pkg::addr_t       d_wt_addr,
  input  cache_pkg::word_t       d_wt_data,
  output logic                   d_wt_done,
  output axi_lite_pkg::axi_req_t axi_req,
  input  axi_lite_pkg::axi_rsp_t axi_rsp,
  output logic                   bus_error
);
  import cache_pkg::*;
  import axi_lite_pkg::*;

  typedef enum logic [2:0] {
    idle,
    read_addr,
    read_data,
    write_req,
    write_resp
  } state_e;

  state_e    state_q;
  logic      owner_d_q;    // 1 when the fill belongs to the d-cache
  addr_t     addr_q;       // block base or write address
  word_t     data_q;
  word_off_t word_cnt_q;
  logic      aw_sent_q;
  logic      w_sent_q;
  logic      r_fire;
  logic      b_fire;
  logic      aw_fire;
  logic      w_fire;
  logic      last_word;
  fill_beat_t beat;

  assign r_fire    = axi_req.rready & axi_rsp.r.valid;
  assign b_fire    = axi_req.bready & axi_rsp.b.valid;
  assign aw_fire   = axi_req.aw.valid & axi_rsp.awready;
  assign w_fire    = axi_req.w.valid & axi_rsp.wready;
  assign last_word = (word_cnt_q == word_off_t'(words_per_block - 1));

  // master side of the bus
  always_comb begin
    axi_req          = '0;
    axi_req.ar.valid = (state_q == read_addr);
    axi_req.ar.addr  = {addr_q[addr_w-1:off_w+1], word_cnt_q, 1'b0};
    axi_req.rready   = (state_q == read_data);
    axi_req.aw.valid = (state_q == write_req) & ~aw_sent_q;
    axi_req.aw.addr  = addr_q;
    axi_req.w.valid  = (state_q == write_req) & ~w_sent_q;
    axi_req.w.data   = data_q;
    axi_req.w.strb   = '1;  // full words only
    axi_req.bready   = (state_q == write_resp);
  end

  // r data goes straight to the owning cache
  assign beat.valid = r_fire;
  assign beat.off   = word_cnt_q;
  assign beat.data  = axi_rsp.r.data;
  assign beat.last  = last_word;

  assign i_beat    = owner_d_q ? '0 : beat;
  assign d_beat    = owner_d_q ? beat : '0;
  assign d_wt_done = b_fire;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q    <= idle;
      owner_d_q  <= 1'b0;
      word_cnt_q <= '0;
      aw_sent_q  <= 1'b0;
      w_sent_q   <= 1'b0;
      bus_error  <= 1'b0;
    end else begin
      case (state_q)
        idle: begin
          word_cnt_q <= '0;
          aw_sent_q  <= 1'b0;
          w_sent_q   <= 1'b0;
          if (d_wt_req) begin              // d write-through first
            state_q <= write_req;
          end else if (d_fill_req) begin
            owner_d_q <= 1'b1;
            state_q   <= read_addr;
          end else if (i_fill_req) begin
            owner_d_q <= 1'b0;
            state_q   <= read_addr;
          end
        end
        read_addr: if (axi_rsp.arready) state_q <= read_data;
        read_data: begin
          if (r_fire) begin
            word_cnt_q <= word_cnt_q + 1'b1;
            state_q    <= last_word ? idle : read_addr;
          end
        end
        write_req: begin
          aw_sent_q <= aw_sent_q | aw_fire;
          w_sent_q  <= w_sent_q | w_fire;
          if ((aw_sent_q | aw_fire) && (w_sent_q | w_fire)) begin
            state_q <= write_resp;
          end
        end
        write_resp: if (b_fire) state_q <= idle;
        default: state_q <= idle;
      endcase
      // sticky, any non-okay response
      if ((r_fire && axi_rsp.r.resp != okay) || (b_fire && axi_rsp.b.resp != okay)) begin
        bus_error <= 1'b1;
      end
    end
  end

  // request payload, captured when leaving idle
  always_ff @(posedge clk) begin
    if (state_q == idle) begin
      if (d_wt_req) begin
        addr_q <= d_wt_addr;
        data_q <= d_wt_data;
      end else if (d_fill_req) begin
        addr_q <= d_fill_addr;
      end else begin
        addr_q <= i_fill_addr;
      end
    end
  end

endmodule

//--- verilog/memory_system.sv
// top level with instruction cache, data cache, fill controller and axi4-lite port
`timescale 1ns/1ns

module memory_system (
  input  logic                   clk,
  input  logic                   reset,
  input  cache_pkg::cpu_req_t    i_req,
  output cache_pkg::word_t       i_rdata,
  output logic                   i_miss,
  input  cache_pkg::cpu_req_t    d_req,
  output cache_pkg::word_t       d_rdata,
  output logic                   d_stall,
  output axi_lite_pkg::axi_req_t axi_req,
  input  axi_lite_pkg::axi_rsp_t axi_rsp,
  output logic                   bus_error
);
  import cache_pkg::*;

  logic       i_fill_req;
  addr_t      i_fill_addr;
  fill_beat_t i_beat;
  logic       d_fill_req;
  addr_t      d_fill_addr;
  fill_beat_t d_beat;
  logic       d_wt_req;
  addr_t      d_wt_addr;
  word_t      d_wt_data;
  logic       d_wt_done;

  i_cache u_i_cache (
    .clk       (clk),
    .reset     (reset),
    .req       (i_req),
    .beat      (i_beat),
    .rdata     (i_rdata),
    .miss      (i_miss),
    .fill_req  (i_fill_req),
    .fill_addr (i_fill_addr)
  );

  d_cache u_d_cache (
    .clk       (clk),
    .reset     (reset),
    .req       (d_req),
    .beat      (d_beat),
    .rdata     (d_rdata),
    .stall     (d_stall),
    .fill_req  (d_fill_req),
    .fill_addr (d_fill_addr),
    .wt_req    (d_wt_req),
    .wt_addr   (d_wt_addr),
    .wt_data   (d_wt_data),
    .wt_done   (d_wt_done)
  );

  // one shared path to memory
  mem_fill_ctrl u_fill_ctrl (
    .clk         (clk),
    .reset       (reset),
    .i_fill_req  (i_fill_req),
    .i_fill_addr (i_fill_addr),
    .i_beat      (i_beat),
    .d_fill_req  (d_fill_req),
    .d_fill_addr (d_fill_addr),
    .d_beat      (d_beat),
    .d_wt_req    (d_wt_req),
    .d_wt_addr   (d_wt_addr),
    .d_wt_data   (d_wt_data),
    .d_wt_done   (d_wt_done),
    .axi_req     (axi_req),
    .axi_rsp     (axi_rsp),
    .bus_error   (bus_error)
  );

endmodule

//--- testbench/memory_system_assert.sv
// bound assertions on axi4-lite handshakes, single transaction and fill beat routing
`timescale 1ns/1ns

module memory_system_assert (
  input logic                   clk,
  input logic                   reset,
  input axi_lite_pkg::axi_req_t axi_req,
  input axi_lite_pkg::axi_rsp_t axi_rsp,
  input cache_pkg::fill_beat_t  i_beat,
  input cache_pkg::fill_beat_t  d_beat,
  input logic                   i_fill_req,
  input logic                   d_fill_req,
  input logic                   bus_error
);
  import cache_pkg::*;
  import axi_lite_pkg::*;

  logic rd_open_q;  // ar accepted, r not seen yet
  logic wr_open_q;  // aw accepted, b not seen yet

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_open_q <= 1'b0;
      wr_open_q <= 1'b0;
    end else begin
      if (axi_req.ar.valid && axi_rsp.arready) begin
        rd_open_q <= 1'b1;
      end else if (axi_req.rready && axi_rsp.r.valid) begin
        rd_open_q <= 1'b0;
      end
      if (axi_req.aw.valid && axi_rsp.awready) begin
        wr_open_q <= 1'b1;
      end else if (axi_req.bready && axi_rsp.b.valid) begin
        wr_open_q <= 1'b0;
      end
    end
  end

  // valid stays up until its ready
  a_ar_hold: assert property (@(posedge clk) disable iff (reset)
    axi_req.ar.valid && !axi_rsp.arready |=> axi_req.ar.valid) else $error("ar valid dropped");
  a_aw_hold: assert property (@(posedge clk) disable iff (reset)
    axi_req.aw.valid && !axi_rsp.awready |=> axi_req.aw.valid) else $error("aw valid dropped");
  a_w_hold: assert property (@(posedge clk) disable iff (reset)
    axi_req.w.valid && !axi_rsp.wready |=> axi_req.w.valid) else $error("w valid dropped");

  // no new address while an earlier transaction is still open
  a_one_txn: assert property (@(posedge clk) disable iff (reset)
    rd_open_q || wr_open_q |-> !axi_req.ar.valid && !axi_req.aw.valid)
    else $error("two in flight");

  // beats only land in a cache that is waiting for them
  a_i_beat: assert property (@(posedge clk) disable iff (reset)
    i_beat.valid |-> i_fill_req) else $error("i beat without miss");
  a_d_beat: assert property (@(posedge clk) disable iff (reset)
    d_beat.valid |-> d_fill_req) else $error("d beat without miss");

  a_no_err: assert property (@(posedge clk) disable iff (reset)
    !bus_error) else $error("bus error flagged");

endmodule

//--- testbench/tb_memory_system.sv
// testbench with clock, reset, lfsr stimulus, axi4-lite memory, cache model, checks, timeout
`timescale 1ns/1ns

module tb_memory_system;
  import cache_pkg::*;
  import axi_lite_pkg::*;

  // 300 random ops plus directed ones, eight reads of up to eight cycles each
  localparam int max_cycles = (300 + 40) * 8 * 8 + 4000;

  logic     clk = 1'b0;
  logic     reset = 1'b1;
  cpu_req_t i_req = '0;
  cpu_req_t d_req = '0;
  word_t    i_rdata;
  word_t    d_rdata;
  logic     i_miss;
  logic     d_stall;
  axi_req_t axi_req;
  axi_rsp_t axi_rsp = '0;
  logic     bus_error;

  logic [31:0] lfsr_q = 32'hc4bd_99d2;
  int          cycle_cnt = 0;
  word_t       mem [32768];      // axi slave contents
  word_t       ref_mem [32768];  // expected contents
  logic        mv [2][2][64];    // [cache][way][set] valid, cache 0 is i, 1 is d
  tag_t        mt [2][2][64];
  logic        ml [2][64];       // lru way per set
  int          ar_wait = 0;
  int          aw_wait = 0;
  int          w_wait = 0;
  logic        aw_got = 1'b0;
  logic        w_got = 1'b0;
  addr_t       wa;
  word_t       wd;

  memory_system DUT (
    .clk(clk), .reset(reset), .i_req(i_req), .i_rdata(i_rdata), .i_miss(i_miss),
    .d_req(d_req), .d_rdata(d_rdata), .d_stall(d_stall), .axi_req(axi_req),
    .axi_rsp(axi_rsp), .bus_error(bus_error)
  );

  bind memory_system memory_system_assert u_assert (
    .clk(clk), .reset(reset), .axi_req(axi_req), .axi_rsp(axi_rsp), .i_beat(i_beat),
    .d_beat(d_beat), .i_fill_req(i_fill_req), .d_fill_req(d_fill_req), .bus_error(bus_error)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  // taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // returns 1 on predicted miss, updates valid, tag and lru like the caches do
  function automatic logic predict_miss(int c, addr_t a, logic wr);
    tag_t     t;
    set_idx_t s;
    logic     v;
    t = a[15:10];
    s = a[9:4];
    for (int w = 0; w < 2; w++) begin
      if (mv[c][w][s] && mt[c][w][s] == t) begin
        ml[c][s] = ~w[0];
        return 1'b0;
      end
    end
    if (!wr) begin  // no write allocate
      v = !mv[c][0][s] ? 1'b0 : (!mv[c][1][s] ? 1'b1 : ml[c][s]);
      mv[c][v][s] = 1'b1;
      mt[c][v][s] = t;
      ml[c][s]    = ~v;
    end
    return 1'b1;
  endfunction

  task automatic check(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic i_read(string name, addr_t a, output int done, output logic missed);
    cpu_req_t r;
    logic     exp_miss;
    r        = '0;
    r.valid  = 1'b1;
    r.addr   = a;
    exp_miss = predict_miss(0, a, 1'b0);
    @(posedge clk);
    i_req <= r;
    @(negedge clk);
    missed = i_miss;
    check({name, " miss"}, exp_miss, i_miss);
    while (i_miss) @(negedge clk);
    check({name, " data"}, ref_mem[a[15:1]], i_rdata);
    done = cycle_cnt;
    @(posedge clk);
    i_req <= '0;
  endtask

  task automatic d_read(string name, addr_t a, output int done, output logic missed);
    cpu_req_t r;
    logic     exp_miss;
    r        = '0;
    r.valid  = 1'b1;
    r.addr   = a;
    exp_miss = predict_miss(1, a, 1'b0);
    @(posedge clk);
    d_req <= r;
    @(negedge clk);
    missed = d_stall;
    check({name, " stall"}, exp_miss, d_stall);
    while (d_stall) @(negedge clk);
    check({name, " data"}, ref_mem[a[15:1]], d_rdata);
    done = cycle_cnt;
    @(posedge clk);
    d_req <= '0;
  endtask

  task automatic d_write(string name, addr_t a, word_t data);
    cpu_req_t r;
    logic     unused_miss;
    r           = '0;
    r.valid     = 1'b1;
    r.write     = 1'b1;
    r.addr      = a;
    r.wdata     = data;
    unused_miss = predict_miss(1, a, 1'b1);  // lru touch on a hit
    ref_mem[a[15:1]] = data;
    @(posedge clk);
    d_req <= r;
    @(negedge clk);
    check({name, " stall"}, 1, d_stall);  // always waits for b
    while (d_stall) @(negedge clk);
    check({name, " memory"}, data, mem[a[15:1]]);
    @(posedge clk);
    d_req <= '0;
  endtask

  // axi4-lite slave, random ready delays of 0 to 3
  always @(posedge clk) begin
    if (reset) begin
      axi_rsp <= '0;
      aw_got  = 1'b0;
      w_got   = 1'b0;
    end else begin
      if (axi_req.ar.valid && axi_rsp.arready) begin
        axi_rsp.arready <= 1'b0;
        axi_rsp.r.valid <= 1'b1;
        axi_rsp.r.data  <= mem[axi_req.ar.addr[15:1]];
        axi_rsp.r.resp  <= okay;
        ar_wait = rand_bits(2);
      end else if (axi_req.ar.valid) begin
        if (ar_wait == 0) axi_rsp.arready <= 1'b1;
        else ar_wait--;
      end
      if (axi_rsp.r.valid && axi_req.rready) axi_rsp.r.valid <= 1'b0;
      if (axi_req.aw.valid && axi_rsp.awready) begin
        axi_rsp.awready <= 1'b0;
        wa      = axi_req.aw.addr;
        aw_got  = 1'b1;
        aw_wait = rand_bits(2);
      end else if (axi_req.aw.valid) begin
        if (aw_wait == 0) axi_rsp.awready <= 1'b1;
        else aw_wait--;
      end
      if (axi_req.w.valid && axi_rsp.wready) begin
        check("w_strb", 2'b11, axi_req.w.strb);  // full words only
        axi_rsp.wready <= 1'b0;
        wd     = axi_req.w.data;
        w_got  = 1'b1;
        w_wait = rand_bits(2);
      end else if (axi_req.w.valid) begin
        if (w_wait == 0) axi_rsp.wready <= 1'b1;
        else w_wait--;
      end
      if (aw_got && w_got) begin  // both halves in, commit and answer
        mem[wa[15:1]] = wd;
        axi_rsp.b.valid <= 1'b1;
        axi_rsp.b.resp  <= okay;
        aw_got = 1'b0;
        w_got  = 1'b0;
      end
      if (axi_rsp.b.valid && axi_req.bready) axi_rsp.b.valid <= 1'b0;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > max_cycles) begin
      $display("timeout, run went past %0d cycles", max_cycles);
      $display("Checks failed");
      $fatal(1);
    end
  end

  initial begin
    int        ic;
    int        dc;
    logic      im;
    logic      dm;
    int        op;
    addr_t     a;
    logic [3:0] r_tag;
    set_idx_t  r_set;
    word_off_t r_off;
    for (int k = 0; k < 32768; k++) begin
      mem[k]     = word_t'(rand_bits(16));
      ref_mem[k] = mem[k];
    end
    for (int c = 0; c < 2; c++) begin
      for (int s = 0; s < 64; s++) begin
        mv[c][0][s] = 1'b0;
        mv[c][1][s] = 1'b0;
        ml[c][s]    = 1'b0;
      end
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    // cold misses
    i_read("first_i", 16'h0000, ic, im);
    d_read("first_d", 16'h8000, dc, dm);
    // write hit, then write miss, each read back
    d_write("wr_hit", 16'h8002, 16'h1234);
    d_read("wr_hit_rd", 16'h8002, dc, dm);
    d_write("wr_miss", {6'h30, 6'd10, 3'd3, 1'b0}, 16'hbeef);
    d_read("wr_miss_rd", {6'h30, 6'd10, 3'd3, 1'b0}, dc, dm);
    // A B A C B in set 5, C evicts B
    d_read("lru_a", {6'h28, 6'd5, 4'h0}, dc, dm);
    d_read("lru_b", {6'h29, 6'd5, 4'h2}, dc, dm);
    d_read("lru_a2", {6'h28, 6'd5, 4'h4}, dc, dm);
    d_read("lru_c", {6'h2a, 6'd5, 4'h6}, dc, dm);
    d_read("lru_b2", {6'h29, 6'd5, 4'h8}, dc, dm);
    check("lru_evict", 1, dm);
    // both caches miss at once, d side wins
    fork
      i_read("dual_i", {6'h1f, 6'd40, 4'h2}, ic, im);
      d_read("dual_d", {6'h3f, 6'd40, 4'h4}, dc, dm);
    join
    check("dual_order", 1, dc < ic);
    for (int n = 0; n < 300; n++) begin
      @(negedge clk);  // draws kept off the slave's edge
      op    = rand_bits(2);
      r_tag = 4'(rand_bits(4));
      r_set = set_idx_t'(rand_bits(6));
      r_off = word_off_t'(rand_bits(3));
      a     = {2'b00, r_tag, r_set, r_off, 1'b0};
      if (op == 0 || op == 3) begin
        i_read("rnd_i", a, ic, im);
      end else if (op == 1) begin
        a[15] = 1'b1;
        d_read("rnd_d_rd", a, dc, dm);
      end else begin
        a[15] = 1'b1;
        d_write("rnd_d_wr", a, word_t'(rand_bits(16)));
      end
    end
    check("bus_error", 0, bus_error);
    $display("All checks passed");
    $finish;
  end

endmodule

//--- tb.f
common/cache_pkg.sv
common/axi_lite_pkg.sv
cache/meta_data_array.sv
cache/data_array.sv
cache/i_cache.sv
cache/d_cache.sv
verilog/mem_fill_ctrl.sv
verilog/memory_system.sv
testbench/memory_system_assert.sv
testbench/tb_memory_system.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_memory_system -f tb.f -o sim_tb

# the sim may exit nonzero on a failed check, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation ok"
